// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_control.sv
hdl/rv_core.sv
testbench/rv_core_properties.sv
testbench/tb_rv_core.sv

// File: hdl/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu import rv_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y
);

	logic [4:0] shamt;

	assign shamt = b[4:0];  // rv32i shifts by 0..31

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_SLL: y = a << shamt;
			ALU_SLT: y = word_t'($signed(a) < $signed(b));
			ALU_SLTU: y = word_t'(a < b);
			ALU_XOR: y = a ^ b;
			ALU_SRL: y = a >> shamt;
			ALU_SRA: y = $signed(a) >>> shamt;
			ALU_OR: y = a | b;
			ALU_AND: y = a & b;
			default: y = '0;  // illegal funct combinations
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/rv_control.sv
`timescale 1ns/1ns
`default_nettype none

module rv_control import rv_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  opcode_t  opcode,
	input  logic     opcode_known,
	input  alu_op_t  funct_alu_op,
	input  logic     branch_negate,
	input  logic     alu_nonzero,
	input  logic     mem_ready,
	output logic     pc_write,
	output logic     ir_write,
	output logic     reg_write,
	output logic     mem_valid,
	output logic     mem_we,
	output logic     addr_from_alu,
	output logic     alu_a_is_pc,
	output logic     alu_b_is_imm,
	output logic     halted,
	output pc_src_t  pc_src,
	output reg_src_t reg_src,
	output alu_op_t  alu_op
);

	phase_t phase;
	phase_t phase_n;

	always_ff @(posedge clk) begin
		if (rst)
			phase <= PH_IF;
		else
			phase <= phase_n;
	end

	// request follows the phase, so it holds steady while memory stalls
	assign mem_valid     = (phase == PH_IF) || (phase == PH_MEM);
	assign mem_we        = (phase == PH_MEM) && (opcode == OPC_STORE);
	assign addr_from_alu = (phase == PH_MEM);
	assign halted        = (phase == PH_HALT);

	always_comb begin
		phase_n      = phase;
		pc_write     = 1'b0;
		pc_src       = PC_PLUS4;
		ir_write     = 1'b0;
		reg_write    = 1'b0;
		reg_src      = REG_ALU;
		alu_a_is_pc  = 1'b0;
		alu_b_is_imm = 1'b0;
		alu_op       = ALU_ADD;
		case (phase)
			PH_IF: begin
				ir_write = mem_ready;
				if (mem_ready)
					phase_n = PH_ID;
			end
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			PH_ID: begin
				pc_write     = opcode_known;  // pc keeps the bad instruction on halt
				alu_a_is_pc  = 1'b1;          // old pc + imm, used by jal, auipc, branch
				alu_b_is_imm = 1'b1;
				if (!opcode_known)
					phase_n = PH_HALT;
				else if (opcode == OPC_FENCE)
					phase_n = PH_IF;
				else if (opcode == OPC_LUI || opcode == OPC_AUIPC || opcode == OPC_JAL)
					phase_n = PH_WB;
				else
					phase_n = PH_EX;
			end
			PH_EX: begin
				alu_op       = funct_alu_op;
				alu_b_is_imm = (opcode != OPC_OP) && (opcode != OPC_BRANCH);
				if (opcode == OPC_LOAD || opcode == OPC_STORE)
					phase_n = PH_MEM;
				else
					phase_n = PH_WB;
			end
			PH_MEM: begin
				alu_b_is_imm = 1'b1;  // recomputes rs1 + imm so the address holds
				if (mem_ready)
					phase_n = (opcode == OPC_LOAD) ? PH_WB : PH_IF;
			end
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			PH_WB: begin
				phase_n   = PH_IF;
				reg_write = 1'b1;
				case (opcode)
					OPC_LUI: reg_src = REG_IMM;
					OPC_LOAD: reg_src = REG_MEM;
					OPC_JAL, OPC_JALR: begin
						reg_src  = REG_LINK;  // pc already advanced by 4
						pc_write = 1'b1;
						pc_src   = (opcode == OPC_JAL) ? PC_JUMP : PC_JUMP_REG;
					end
					OPC_BRANCH: begin
						reg_write = 1'b0;
						pc_write  = alu_nonzero != branch_negate;
						pc_src    = PC_BRANCH_TARGET;
					end
					default: reg_src = REG_ALU;  // auipc, op, op-imm
				endcase
			end
			default: phase_n = PH_HALT;  // PH_HALT waits for reset
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core import rv_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	output logic  mem_valid,
	output logic  mem_we,
	output word_t mem_addr,
	output word_t mem_wdata,
	input  word_t mem_rdata,
	input  logic  mem_ready,
	output logic  halted
);

	// control
	logic     pc_write;
	logic     ir_write;
	logic     reg_write;
	logic     addr_from_alu;
	logic     alu_a_is_pc;
	logic     alu_b_is_imm;
	pc_src_t  pc_src;
	reg_src_t reg_src;
	alu_op_t  alu_op;

	// decode
	opcode_t  opcode;
	logic     opcode_known;
	alu_op_t  funct_alu_op;
	logic     branch_negate;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    imm;

	// datapath
	word_t pc;
	word_t pc_next;
	word_t ir;
	word_t a_q;
	word_t b_q;
	word_t alu_out;
	word_t prev_out;  // branch target from the ID phase
	word_t mdr;
	word_t rf_rd0;
	word_t rf_rd1;
	word_t alu_a;
	word_t alu_b;
	word_t alu_y;
	word_t wb_data;
	word_t addr;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `RV_START_ADDR;
		else if (pc_write)
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (ir_write)
			ir <= mem_rdata;
	end

	always_ff @(posedge clk) begin
		a_q      <= rf_rd0;
		b_q      <= rf_rd1;   // stable through MEM since ir is held
		alu_out  <= alu_y;
		prev_out <= alu_out;
		mdr      <= mem_rdata;  // holds the handshake word in WB
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// muxes
	always_comb begin
		case (pc_src)
			PC_BRANCH_TARGET: pc_next = prev_out;
			PC_JUMP: pc_next = alu_out;
			PC_JUMP_REG: pc_next = {alu_out[`RV_XLEN-1:1], 1'b0};
			default: pc_next = pc + 4;
		endcase
	end

	always_comb begin
		case (reg_src)
			REG_IMM: wb_data = imm;
			REG_LINK: wb_data = pc;
			REG_MEM: wb_data = mdr;
			default: wb_data = alu_out;
		endcase
	end

	assign alu_a = alu_a_is_pc ? pc : a_q;
	assign alu_b = alu_b_is_imm ? imm : b_q;

	assign addr      = addr_from_alu ? alu_out : pc;
	assign mem_addr  = {addr[`RV_XLEN-1:2], 2'b00};  // word accesses only
	assign mem_wdata = b_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	rv_control u_control (
		.clk(clk), .rst(rst),
		.opcode(opcode), .opcode_known(opcode_known),
		.funct_alu_op(funct_alu_op), .branch_negate(branch_negate),
		.alu_nonzero(|alu_out), .mem_ready(mem_ready),
		.pc_write(pc_write), .ir_write(ir_write), .reg_write(reg_write),
		.mem_valid(mem_valid), .mem_we(mem_we), .addr_from_alu(addr_from_alu),
		.alu_a_is_pc(alu_a_is_pc), .alu_b_is_imm(alu_b_is_imm), .halted(halted),
		.pc_src(pc_src), .reg_src(reg_src), .alu_op(alu_op)
	);

	rv_decoder u_decoder (
		.instr(ir), .opcode(opcode), .opcode_known(opcode_known),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.funct_alu_op(funct_alu_op), .branch_negate(branch_negate)
	);

	rv_alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

	rv_regfile u_regfile (
		.clk(clk), .ra0(rs1), .ra1(rs2), .wa(rd),
		.we(reg_write), .wd(wb_data), .rd0(rf_rd0), .rd1(rf_rd1)
	);

endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_decoder import rv_pkg::*; (
	input  word_t    instr,
	output opcode_t  opcode,
	output logic     opcode_known,
	output reg_idx_t rs1,
	output reg_idx_t rs2,
	output reg_idx_t rd,
	output word_t    imm,
	output alu_op_t  funct_alu_op,
	output logic     branch_negate
);

	logic [2:0] funct3;
	logic       alt;

	assign opcode = opcode_t'(instr[`RV_OPCODE_LSB +: 7]);
	assign rd     = instr[`RV_RD_LSB +: 5];
	assign rs1    = instr[`RV_RS1_LSB +: 5];
	assign rs2    = instr[`RV_RS2_LSB +: 5];
	assign funct3 = instr[`RV_FUNCT3_LSB +: 3];
	assign alt    = instr[`RV_ALT_BIT];

	// immediate format per opcode
	always_comb begin
		opcode_known = 1'b1;
		case (opcode)
			OPC_LUI, OPC_AUIPC: imm = {instr[31:12], 12'b0};
			OPC_JAL: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			OPC_JALR, OPC_LOAD, OPC_OP_IMM: imm = {{21{instr[31]}}, instr[30:20]};
			OPC_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			OPC_STORE: imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			OPC_OP, OPC_FENCE: imm = '0;
			default: begin
				imm = '0;
				opcode_known = 1'b0;  // sends the core to halt
			end
		endcase
	end

	always_comb begin
		case (opcode)
			OPC_OP: funct_alu_op = alu_op_t'({alt, funct3});
			OPC_OP_IMM: funct_alu_op = alu_op_t'({alt & (funct3 == 3'b101), funct3}); // srai only
			OPC_BRANCH: funct_alu_op = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
			default: funct_alu_op = ALU_ADD;  // address and jalr target
		endcase
	end

	// beq, bge, bgeu branch on a zero compare result
	assign branch_negate = funct3[2] ? funct3[0] : ~funct3[0];

endmodule

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// major opcodes handled by the core
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_FENCE  = 7'b0001111  // treated as nop
	} opcode_t;

	typedef enum logic [2:0] {
		PH_IF,
		PH_ID,
		PH_EX,
		PH_MEM,
		PH_WB,
		PH_HALT
	} phase_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// {bit 30, funct3} of the instruction
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_op_t;

	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH_TARGET, PC_JUMP, PC_JUMP_REG} pc_src_t;

	typedef enum logic [1:0] {REG_ALU, REG_IMM, REG_LINK, REG_MEM} reg_src_t;

endpackage

`default_nettype wire

// File: hdl/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_regfile import rv_pkg::*; (
	input  logic     clk,
	input  reg_idx_t ra0,
	input  reg_idx_t ra1,
	input  reg_idx_t wa,
	input  logic     we,
	input  word_t    wd,
	output word_t    rd0,
	output word_t    rd1
);

	word_t regs [`RV_REG_COUNT];

	always_ff @(posedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

	// x0 is never written, so read it as zero here
	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

`default_nettype wire

// File: hdl/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// machine sizes
`define RV_XLEN        32
`define RV_REG_COUNT   32

`define RV_START_ADDR  32'h0000_0000  // first fetch after reset

// instruction field positions, lsb of each field
`define RV_OPCODE_LSB  0
`define RV_RD_LSB      7
`define RV_FUNCT3_LSB  12
`define RV_RS1_LSB     15
`define RV_RS2_LSB     20

// funct7 bit that picks sub and sra
`define RV_ALT_BIT     30

`endif

// File: testbench/rv_core_properties.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_properties import rv_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  mem_valid,
	input logic  mem_we,
	input word_t mem_addr,
	input word_t mem_wdata,
	input logic  mem_ready,
	input logic  halted
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stalled request stays put, wdata only matters on writes
	hold_request: assert property (@(posedge clk) disable iff (rst)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_we)
			&& (!mem_we || $stable(mem_wdata)))
		else $error("request changed while waiting for mem_ready");

	we_needs_valid: assert property (@(posedge clk) disable iff (rst)
		mem_we |-> mem_valid)
		else $error("mem_we high without mem_valid");

	halt_is_quiet: assert property (@(posedge clk) disable iff (rst)
		halted |=> halted && !mem_valid)
		else $error("core left halt or requested memory");

endmodule

bind rv_core rv_core_properties u_properties (
	.clk(clk), .rst(rst), .mem_valid(mem_valid), .mem_we(mem_we),
	.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_ready(mem_ready),
	.halted(halted)
);

`default_nettype wire

// File: testbench/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

	localparam int MEM_WORDS = 1024;
	localparam int MAX_DELAY = 3;
	localparam int PHASES    = 5;   // longest instruction, IF to WB
	localparam word_t BASE    = 32'h0000_0400;  // result area
	localparam word_t SCRATCH = 32'h0000_0600;

	logic  clk = 1'b0;
	logic  rst = 1'b1;
	logic  mem_ready = 1'b0;
	word_t mem_rdata;
	logic  mem_valid;
	logic  mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	logic  halted;

	word_t mem [MEM_WORDS];
	word_t prog [$];
	string exp_name [$];
	word_t exp_addr [$];
	word_t exp_data [$];

	int     errors = 0;
	int     store_idx = 0;
	int     next_off = 0;
	int     cycles;
	int     limit;
	int     wait_left;
	int     draw;
	integer seed = 32'h1d2a_d94e;

	always #2 clk = ~clk;

	rv_core u_dut (
		.clk(clk), .rst(rst),
		.mem_valid(mem_valid), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready),
		.halted(halted)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// instruction encoders
	function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
			input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input int f3,
			input int rd, input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_s(input int imm, input int rs2, input int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t enc_b(input int imm, input int rs2, input int rs1,
			input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			OPC_BRANCH};
	endfunction

	function automatic word_t enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
	endfunction

	function automatic word_t cur_pc();
		return word_t'(prog.size() * 4);
	endfunction

	task automatic emit(input word_t w);
		prog.push_back(w);
	endtask

	task automatic expect_store(input string name, input word_t addr, input word_t data);
		exp_name.push_back(name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// sw rs to the next result slot
	task automatic store_result(input string name, input int rs, input word_t exp);
		emit(enc_s(next_off, rs, 10));
		expect_store(name, BASE + word_t'(next_off), exp);
		next_off += 4;
	endtask

	// marker 1 if taken, 2 if the fall-through ran
	task automatic branch_case(input string name, input int f3, input int rs1,
			input int rs2, input logic taken);
		emit(enc_i(1, 0, 0, 20, OPC_OP_IMM));
		emit(enc_b(8, rs2, rs1, f3));
		emit(enc_i(2, 0, 0, 20, OPC_OP_IMM));
		store_result(name, 20, taken ? 32'd1 : 32'd2);
	endtask

	task automatic check(input string name, input word_t exp, input word_t act);
		if (exp !== act) begin
			$display("[FAIL] %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic record_store(input word_t addr, input word_t data);
		if (store_idx >= exp_addr.size()) begin
			$display("unexpected store of %h to %h after the last expected one", data, addr);
			errors++;
		end else begin
			check({exp_name[store_idx], " addr"}, exp_addr[store_idx], addr);
			check({exp_name[store_idx], " data"}, exp_data[store_idx], data);
		end
		store_idx++;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program image, x1 = 5 and x2 = -3 throughout
	task automatic build_program();
		word_t p;
		emit(enc_i(32'h400, 0, 0, 10, OPC_OP_IMM));
		emit(enc_i(5, 0, 0, 1, OPC_OP_IMM));
		emit(enc_i(-3, 0, 0, 2, OPC_OP_IMM));
		emit(enc_r(0, 2, 1, 0, 3));
		store_result("add", 3, 32'd2);
		emit(enc_r(32, 2, 1, 0, 4));
		store_result("sub", 4, 32'd8);
		emit(enc_i(3, 1, 1, 5, OPC_OP_IMM));
		store_result("slli", 5, 32'd40);
		emit(enc_i(32'h401, 2, 5, 6, OPC_OP_IMM));
		store_result("srai", 6, 32'hffff_fffe);
		emit(enc_i(28, 2, 5, 7, OPC_OP_IMM));
		store_result("srli", 7, 32'h0000_000f);
		emit(enc_r(0, 1, 2, 2, 8));
		store_result("slt", 8, 32'd1);
		emit(enc_r(0, 1, 2, 3, 9));
		store_result("sltu", 9, 32'd0);
		emit(enc_r(0, 2, 1, 4, 11));
		store_result("xor", 11, 32'hffff_fff8);
		emit(enc_r(0, 2, 1, 6, 12));
		store_result("or", 12, 32'hffff_fffd);
		emit(enc_r(0, 2, 1, 7, 13));
		store_result("and", 13, 32'd5);
		emit(enc_i(7, 1, 0, 0, OPC_OP_IMM));  // write to x0
		store_result("x0", 0, 32'd0);
		emit(enc_u(32'h12345, 14, OPC_LUI));
		store_result("lui", 14, 32'h1234_5000);
		p = cur_pc();
		emit(enc_u(1, 15, OPC_AUIPC));
		store_result("auipc", 15, p + 32'h1000);
		emit(enc_i(32'h55, 0, 0, 17, OPC_OP_IMM));
		p = cur_pc();
		emit(enc_j(8, 16));
		emit(enc_i(32'h66, 0, 0, 17, OPC_OP_IMM));  // skipped
		store_result("jal link", 16, p + 4);
		store_result("jal skip", 17, 32'h55);
		p = cur_pc();
		emit(enc_i(p + 12, 0, 0, 18, OPC_OP_IMM));
		emit(enc_i(0, 18, 0, 19, OPC_JALR));
		emit(enc_i(32'h77, 0, 0, 17, OPC_OP_IMM));  // skipped
		store_result("jalr link", 19, p + 8);
		store_result("jalr skip", 17, 32'h55);
		branch_case("beq taken", 0, 1, 1, 1'b1);
		branch_case("beq not taken", 0, 1, 2, 1'b0);
		branch_case("bne taken", 1, 1, 2, 1'b1);
		branch_case("bne not taken", 1, 1, 1, 1'b0);
		branch_case("blt taken", 4, 2, 1, 1'b1);
		branch_case("blt not taken", 4, 1, 2, 1'b0);
		branch_case("bge taken", 5, 1, 2, 1'b1);
		branch_case("bge not taken", 5, 2, 1, 1'b0);
		branch_case("bltu taken", 6, 1, 2, 1'b1);
		branch_case("bltu not taken", 6, 2, 1, 1'b0);
		branch_case("bgeu taken", 7, 2, 1, 1'b1);
		branch_case("bgeu not taken", 7, 1, 2, 1'b0);
		emit(enc_i(32'h600, 0, 0, 21, OPC_OP_IMM));
		emit(enc_s(0, 11, 21));
		expect_store("sw scratch", SCRATCH, 32'hffff_fff8);
		emit(32'h0000_000f);  // fence
		emit(enc_i(0, 21, 2, 22, OPC_LOAD));
		store_result("lw", 22, 32'hffff_fff8);
		emit(32'hffff_ffff);  // unknown opcode, halts
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory model where every request waits 0..3 cycles
	assign mem_rdata = mem[mem_addr[11:2]];

	always @(posedge clk) begin
		if (rst) begin
			mem_ready <= 1'b0;
			wait_left <= 2;
		end else if (mem_valid && mem_ready) begin
			if (mem_we) begin
				mem[mem_addr[11:2]] <= mem_wdata;
				record_store(mem_addr, mem_wdata);
			end
			draw = $random(seed) & MAX_DELAY;
			mem_ready <= (draw == 0);
			wait_left <= draw;
		end else if (mem_valid) begin
			if (wait_left <= 1)
				mem_ready <= 1'b1;
			wait_left <= wait_left - 1;
		end
	end

	initial begin
		build_program();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'ha5a5_0000 ^ word_t'(i * 4);
		for (int i = 0; i < prog.size(); i++)
			mem[i] = prog[i];
		limit = prog.size() * PHASES * (MAX_DELAY + 1) * 2;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		cycles = 0;
		while (!halted && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end

		if (!halted) begin
			$display("timeout: core did not halt within %0d cycles", limit);
			errors++;
		end else begin
			repeat (8) begin
				@(negedge clk);
				if (mem_valid) begin
					$display("memory request to %h seen after halt", mem_addr);
					errors++;
				end
			end
		end
		if (store_idx != exp_addr.size()) begin
			$display("saw %0d stores but expected %0d", store_idx, exp_addr.size());
			errors++;
		end

		$display("errors: %0d, stores seen: %0d of %0d", errors, store_idx,
			exp_addr.size());
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire
